// File: dwnld_pkg.sv
/* Shared widths, download index codes and reset values
   for the ROM download pipeline */

package dwnld_pkg;

    // Firmware side of the link
    typedef logic [26:0] dwnld_addr_t;
    typedef logic [15:0] word_t;

    // Loader side, one byte per write
    typedef logic [24:0] ioctl_addr_t;
    typedef logic [7:0]  byte_t;

    // What a transfer holds
    typedef logic [7:0]  index_t;

    // Configuration registers
    typedef logic [6:0]  core_mod_t;
    typedef logic [31:0] dipsw_t;

    // Download index codes
    localparam index_t IDX_ROM      = 8'd0;
    localparam index_t IDX_CORE_MOD = 8'd1;
    localparam index_t IDX_NVRAM    = 8'd2;
    localparam index_t IDX_DIP      = 8'd254;

    // DIP word is built from this many bytes, byte 0 lowest
    localparam int DIP_BYTES = 4;

    // Only bit 0 set out of reset
    localparam core_mod_t CORE_MOD_RESET = 7'b000_0001;

    // All switches off until the MRA file says otherwise
    localparam dipsw_t DIPSW_RESET = 32'hffff_ffff;

endpackage

// File: dwnld_if.sv
/* Byte-write interface from splitter to decoder and
   configuration-write interface from decoder to registers */

`timescale 1ns/1ps

interface byte_wr_if import dwnld_pkg::*; ();

    logic        wr;
    ioctl_addr_t addr;
    byte_t       data;
    index_t      index;

    modport src (
        output wr,
        output addr,
        output data,
        output index
    );

    modport dst (
        input wr,
        input addr,
        input data,
        input index
    );

endinterface

interface cfg_wr_if import dwnld_pkg::*; ();

    logic                         dip_we;
    logic                         core_we;
    logic [$clog2(DIP_BYTES)-1:0] sel;
    byte_t                        data;

    modport src (
        output dip_we,
        output core_we,
        output sel,
        output data
    );

    modport dst (
        input dip_we,
        input core_we,
        input sel,
        input data
    );

endinterface

// File: dwnld_splitter.sv
/* Stage 1: splits 16-bit firmware writes into two byte writes
   and passes NVRAM writes through as single bytes */

`timescale 1ns/1ps

module dwnld_splitter import dwnld_pkg::*; #(
    parameter int DWNLD_GAP = 24
) (
    input  logic        clk_rom,
    input  logic        rst,
    input  logic        dwnld_wr,
    input  dwnld_addr_t dwnld_addr,
    input  word_t       dwnld_data,
    input  index_t      ioctl_index,
    input  logic        ioctl_download,
    output logic        ioctl_ram,
    byte_wr_if.src      bytes
);

    localparam int CNT_W = $clog2(DWNLD_GAP);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_HIGH
    } split_state_t;

    split_state_t     state;
    logic [CNT_W-1:0] gap_cnt;

    // Word held for both byte writes
    word_t       word_q;
    ioctl_addr_t addr_q;
    logic        word_ram;

    logic accept;
    logic low_slot;

    assign accept   = (state == ST_IDLE) && dwnld_wr;
    assign low_slot = (state == ST_WAIT) && (gap_cnt == '0);

    always_ff @(posedge clk_rom or posedge rst) begin
        if (rst) begin
            state     <= ST_IDLE;
            gap_cnt   <= '0;
            bytes.wr  <= 1'b0;
            ioctl_ram <= 1'b0;
        end else begin
            ioctl_ram <= ioctl_download && (ioctl_index == IDX_NVRAM);
            bytes.wr  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (dwnld_wr) begin
                        state   <= ST_WAIT;
                        gap_cnt <= '0;
                    end
                end
                ST_WAIT: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_cnt == '0) begin
                        bytes.wr <= 1'b1;
                    end
                    // NVRAM is a single byte, no high half
                    if (gap_cnt == '0 && word_ram) begin
                        state <= ST_IDLE;
                    end else if (gap_cnt == CNT_W'(DWNLD_GAP - 1)) begin
                        state <= ST_HIGH;
                    end
                end
                ST_HIGH: begin
                    bytes.wr <= 1'b1;
                    state    <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_rom) begin
        // Index tracks the firmware while idle, then holds for the word
        if (state == ST_IDLE) begin
            bytes.index <= ioctl_index;
        end
        if (accept) begin
            word_q   <= dwnld_data;
            addr_q   <= dwnld_addr[24:0];
            word_ram <= ioctl_ram;
        end
        if (low_slot) begin
            bytes.addr <= word_ram ? addr_q : {addr_q[24:1], 1'b0};
            bytes.data <= word_q[7:0];
        end else if (state == ST_HIGH) begin
            bytes.addr <= {addr_q[24:1], 1'b1};
            bytes.data <= word_q[15:8];
        end
    end

    // Firmware must leave room for both halves before the next word
    a_no_overrun: assert property (
        @(posedge clk_rom) disable iff (rst)
        dwnld_wr |-> state == ST_IDLE
    );

endmodule

// File: dwnld_decoder.sv
/* Stage 2: sorts byte writes by download index into ROM loader
   writes and configuration register writes */

`timescale 1ns/1ps

module dwnld_decoder import dwnld_pkg::*; (
    input  logic        clk_rom,
    input  logic        rst,
    input  logic        ioctl_download,
    byte_wr_if.dst      bytes,
    output ioctl_addr_t ioctl_addr,
    output byte_t       ioctl_data,
    output logic        ioctl_rom_wr,
    output logic        downloading,
    cfg_wr_if.src       cfg
);

    logic is_rom;
    logic is_dip;
    logic is_core;

    assign is_rom  = bytes.index == IDX_ROM;
    assign is_dip  = (bytes.index == IDX_DIP) && (bytes.addr[24:2] == '0);

    // High byte of a mode word lands on an odd address and is dropped
    assign is_core = (bytes.index == IDX_CORE_MOD) && !bytes.addr[0];

    always_ff @(posedge clk_rom or posedge rst) begin
        if (rst) begin
            ioctl_rom_wr <= 1'b0;
            downloading  <= 1'b0;
            cfg.dip_we   <= 1'b0;
            cfg.core_we  <= 1'b0;
        end else begin
            downloading  <= ioctl_download && is_rom;
            ioctl_rom_wr <= bytes.wr && is_rom;
            cfg.dip_we   <= bytes.wr && is_dip;
            cfg.core_we  <= bytes.wr && is_core;
        end
    end

    // Loader sees every byte, whatever its index
    always_ff @(posedge clk_rom) begin
        if (bytes.wr) begin
            ioctl_addr <= bytes.addr;
            ioctl_data <= bytes.data;
            cfg.sel    <= bytes.addr[1:0];
            cfg.data   <= bytes.data;
        end
    end

    a_cfg_onehot: assert property (
        @(posedge clk_rom) disable iff (rst)
        !(cfg.dip_we && cfg.core_we)
    );

endmodule

// File: dwnld_cfg_regs.sv
/* Stage 3: DIP-switch bytes from the MRA file and the
   core mode register */

`timescale 1ns/1ps

module dwnld_cfg_regs import dwnld_pkg::*; (
    input  logic      clk_rom,
    input  logic      rst,
    cfg_wr_if.dst     cfg,
    output dipsw_t    dipsw,
    output core_mod_t core_mod
);

    byte_t dsw [DIP_BYTES];

    always_ff @(posedge clk_rom or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DIP_BYTES; i++) begin
                dsw[i] <= DIPSW_RESET[i*8 +: 8];
            end
        end else if (cfg.dip_we) begin
            dsw[cfg.sel] <= cfg.data;
        end
    end

    // Byte 0 in the lowest bits
    assign dipsw = {dsw[3], dsw[2], dsw[1], dsw[0]};

    always_ff @(posedge clk_rom or posedge rst) begin
        if (rst) begin
            core_mod <= CORE_MOD_RESET;
        end else if (cfg.core_we) begin
            // Bit 7 of the byte has no meaning
            core_mod <= cfg.data[6:0];
        end
    end

endmodule

// File: dwnld_top.sv
/* Download path top level: splitter, decoder and
   configuration registers chained on clk_rom */

`timescale 1ns/1ps

module dwnld_top import dwnld_pkg::*; #(
    parameter int DWNLD_GAP = 24
) (
    input  logic        clk_rom,
    input  logic        rst,
    input  logic        dwnld_wr,
    input  dwnld_addr_t dwnld_addr,
    input  word_t       dwnld_data,
    input  index_t      ioctl_index,
    input  logic        ioctl_download,
    output ioctl_addr_t ioctl_addr,
    output byte_t       ioctl_data,
    output logic        ioctl_rom_wr,
    output logic        ioctl_ram,
    output logic        downloading,
    output dipsw_t      dipsw,
    output core_mod_t   core_mod
);

    byte_wr_if bytes_if ();
    cfg_wr_if  cfg_if ();

    dwnld_splitter #(
        .DWNLD_GAP      ( DWNLD_GAP      )
    ) u_splitter (
        .clk_rom        ( clk_rom        ),
        .rst            ( rst            ),
        .dwnld_wr       ( dwnld_wr       ),
        .dwnld_addr     ( dwnld_addr     ),
        .dwnld_data     ( dwnld_data     ),
        .ioctl_index    ( ioctl_index    ),
        .ioctl_download ( ioctl_download ),
        .ioctl_ram      ( ioctl_ram      ),
        .bytes          ( bytes_if.src   )
    );

    dwnld_decoder u_decoder (
        .clk_rom        ( clk_rom        ),
        .rst            ( rst            ),
        .ioctl_download ( ioctl_download ),
        .bytes          ( bytes_if.dst   ),
        .ioctl_addr     ( ioctl_addr     ),
        .ioctl_data     ( ioctl_data     ),
        .ioctl_rom_wr   ( ioctl_rom_wr   ),
        .downloading    ( downloading    ),
        .cfg            ( cfg_if.src     )
    );

    dwnld_cfg_regs u_cfg_regs (
        .clk_rom        ( clk_rom        ),
        .rst            ( rst            ),
        .cfg            ( cfg_if.dst     ),
        .dipsw          ( dipsw          ),
        .core_mod       ( core_mod       )
    );

endmodule

// File: tb_dwnld_top.sv
/* Testbench for the download path: a table of firmware word writes
   with expected ROM pulses, flags and configuration register values */

`timescale 1ns/1ps

module tb_dwnld_top import dwnld_pkg::*; ();

    localparam int DWNLD_GAP = 24;
    localparam int DRAIN     = DWNLD_GAP + 8;
    localparam int TIMEOUT   = 4 * DWNLD_GAP;

    typedef struct packed {
        index_t      index;
        logic        download;
        dwnld_addr_t addr;
        word_t       data;
        logic [1:0]  rom_pulses;
        logic        ram;
        dipsw_t      dipsw;
        core_mod_t   core_mod;
    } row_t;

    logic        clk_rom;
    logic        rst;
    logic        dwnld_wr;
    dwnld_addr_t dwnld_addr;
    word_t       dwnld_data;
    index_t      ioctl_index;
    logic        ioctl_download;
    ioctl_addr_t ioctl_addr;
    byte_t       ioctl_data;
    logic        ioctl_rom_wr;
    logic        ioctl_ram;
    logic        downloading;
    dipsw_t      dipsw;
    core_mod_t   core_mod;

    row_t        rows [$];
    dipsw_t      ref_dipsw;
    core_mod_t   ref_core;
    int          cyc = 0;
    int          errors = 0;
    int          tests_failed = 0;
    int          wr_cyc;

    // ROM write pulses seen by the monitor
    int          pulse_cyc [$];
    ioctl_addr_t pulse_addr [$];
    byte_t       pulse_data [$];
    logic        pulse_dl [$];

    dwnld_top #(.DWNLD_GAP(DWNLD_GAP)) u_dut (.*);

    initial begin
        clk_rom = 1'b0;
        forever #4 clk_rom = ~clk_rom;
    end

    always @(posedge clk_rom) cyc <= cyc + 1;

    // Sampled on the falling edge, clear of any output change
    always @(negedge clk_rom) begin
        if (ioctl_rom_wr) begin
            pulse_cyc.push_back(cyc);
            pulse_addr.push_back(ioctl_addr);
            pulse_data.push_back(ioctl_data);
            pulse_dl.push_back(downloading);
        end
    end

    task automatic expect_eq(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("Test %0d %s: PASS", num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAIL", num, name);
        end
    endtask

    // Expected registers after each word
    task automatic add_row(input index_t idx, input logic dl, input dwnld_addr_t addr,
                           input word_t data);
        row_t        r;
        ioctl_addr_t lo_addr;
        ioctl_addr_t hi_addr;
        lo_addr = {addr[24:1], 1'b0};
        hi_addr = {addr[24:1], 1'b1};
        if (idx == IDX_DIP && addr[24:2] == '0) begin
            ref_dipsw[8*int'(lo_addr[1:0]) +: 8] = data[7:0];
            ref_dipsw[8*int'(hi_addr[1:0]) +: 8] = data[15:8];
        end
        // Only the low byte of a mode word counts
        if (idx == IDX_CORE_MOD) begin
            ref_core = data[6:0];
        end
        r.index      = idx;
        r.download   = dl;
        r.addr       = addr;
        r.data       = data;
        r.rom_pulses = (idx == IDX_ROM) ? 2'd2 : 2'd0;
        r.ram        = dl && (idx == IDX_NVRAM);
        r.dipsw      = ref_dipsw;
        r.core_mod   = ref_core;
        rows.push_back(r);
    endtask

    function automatic bit row_done(input row_t r);
        return pulse_cyc.size() >= int'(r.rom_pulses) && dipsw === r.dipsw
            && core_mod === r.core_mod;
    endfunction

    task automatic run_row(input int n);
        row_t r;
        int   t;
        int   errs_before;
        r = rows[n];
        errs_before = errors;
        pulse_cyc.delete();
        pulse_addr.delete();
        pulse_data.delete();
        pulse_dl.delete();
        @(posedge clk_rom);
        ioctl_index    <= r.index;
        ioctl_download <= r.download;
        // Let the NVRAM flag settle before the word
        repeat (2) @(posedge clk_rom);
        dwnld_wr   <= 1'b1;
        dwnld_addr <= r.addr;
        dwnld_data <= r.data;
        @(posedge clk_rom);
        dwnld_wr <= 1'b0;
        @(negedge clk_rom);
        wr_cyc = cyc;
        expect_eq("ioctl_ram", 32'(ioctl_ram), 32'(r.ram));
        if (r.ram) begin
            t = 0;
            while (cyc < wr_cyc + 2 && t < TIMEOUT) begin
                @(negedge clk_rom);
                t++;
            end
            expect_eq("NVRAM ioctl_addr", 32'(ioctl_addr), 32'(r.addr[24:0]));
            expect_eq("NVRAM ioctl_data", 32'(ioctl_data), 32'(r.data[7:0]));
        end
        t = 0;
        while (!row_done(r) && t < TIMEOUT) begin
            @(negedge clk_rom);
            t++;
        end
        if (!row_done(r)) begin
            errors++;
            $display("Test %0d timed out waiting for ROM pulses or register update", n + 1);
        end
        // High byte is due GAP cycles after the low one
        repeat (DRAIN) @(negedge clk_rom);
        expect_eq("ROM pulse count", 32'(pulse_cyc.size()), 32'(r.rom_pulses));
        if (pulse_cyc.size() == 2) begin
            expect_eq("first pulse delay", 32'(pulse_cyc[0] - wr_cyc), 32'd2);
            expect_eq("pulse gap", 32'(pulse_cyc[1] - pulse_cyc[0]), 32'(DWNLD_GAP));
            expect_eq("low byte addr", 32'(pulse_addr[0]), 32'({r.addr[24:1], 1'b0}));
            expect_eq("high byte addr", 32'(pulse_addr[1]), 32'({r.addr[24:1], 1'b1}));
            expect_eq("low byte data", 32'(pulse_data[0]), 32'(r.data[7:0]));
            expect_eq("high byte data", 32'(pulse_data[1]), 32'(r.data[15:8]));
            for (int i = 0; i < 2; i++) begin
                expect_eq("downloading", 32'(pulse_dl[i]), 32'(r.download));
            end
        end
        expect_eq("dipsw", dipsw, r.dipsw);
        expect_eq("core_mod", 32'(core_mod), 32'(r.core_mod));
        report_test(n + 1, $sformatf("index %0d addr %0h", r.index, r.addr), errs_before);
    endtask

    initial begin
        int errs_before;
        rst            <= 1'b1;
        dwnld_wr       <= 1'b0;
        dwnld_addr     <= '0;
        dwnld_data     <= '0;
        ioctl_index    <= IDX_ROM;
        ioctl_download <= 1'b0;
        void'($urandom(32'hdf54_4535));
        ref_dipsw = 32'hffff_ffff;
        ref_core  = 7'b000_0001;
        add_row(IDX_ROM, 1'b1, 27'h000_0100, word_t'($urandom()));
        add_row(IDX_ROM, 1'b1, 27'h001_2345, word_t'($urandom()));
        add_row(IDX_ROM, 1'b0, 27'h600_0042, word_t'($urandom()));
        add_row(IDX_NVRAM, 1'b1, 27'h000_0457, 16'ha5c3);
        add_row(IDX_DIP, 1'b1, 27'h000_0000, 16'h3412);
        add_row(IDX_DIP, 1'b1, 27'h000_0002, 16'h7856);
        add_row(IDX_DIP, 1'b1, 27'h000_0004, 16'hdead);
        add_row(IDX_CORE_MOD, 1'b1, 27'h000_0000, 16'hff9a);
        add_row(IDX_ROM, 1'b1, 27'h0ff_fffe, word_t'($urandom()));
        repeat (10) @(posedge clk_rom);
        rst <= 1'b0;
        repeat (2) @(negedge clk_rom);
        errs_before = errors;
        expect_eq("core_mod after reset", 32'(core_mod), 32'h01);
        expect_eq("dipsw after reset", dipsw, 32'hffff_ffff);
        expect_eq("ioctl_rom_wr after reset", 32'(ioctl_rom_wr), 32'd0);
        expect_eq("ioctl_ram after reset", 32'(ioctl_ram), 32'd0);
        expect_eq("downloading after reset", 32'(downloading), 32'd0);
        report_test(0, "reset values", errs_before);
        for (int n = 0; n < rows.size(); n++) begin
            run_row(n);
        end
        $display("Tests run: %0d, failed: %0d, mismatches: %0d",
                 rows.size() + 1, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: compile.f
dwnld_pkg.sv
dwnld_if.sv
dwnld_splitter.sv
dwnld_decoder.sv
dwnld_cfg_regs.sv
dwnld_top.sv
tb_dwnld_top.sv

// File: Makefile
# Verilator build and run of the download path testbench

VERILATOR ?= verilator
TOP       ?= tb_dwnld_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert

PASS_MSG := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Result: passed"; \
	else \
		echo "Result: failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
